/* Makefile */
# Verilator build and run of the ULA testbench

OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module ulaTb \
		-f ula.f -Mdir $(OBJ) -o ulaSim

run: compile
	$(OBJ)/ulaSim | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then \
		echo "Simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "TEST OK" sim.log; then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ) sim.log

/* common/ulaPkg.sv */
package ulaPkg;

   ////////////////////
   // Raster geometry
   ////////////////////

   // 48K line and frame length in pixel clocks
   localparam int hTotal = 448;
   localparam int vTotal = 312;

   // Visible paper area
   localparam int paperWidth  = 256;
   localparam int paperHeight = 192;

   // Sync pulses, both ends inclusive
   localparam int hSyncStart = 344;
   localparam int hSyncEnd   = 375;
   localparam int vSyncStart = 248;
   localparam int vSyncEnd   = 251;

   // Flash divider steps at the start of this line
   localparam int flashLine = 248;

   // Paper output trails the fetch window by one character cell
   localparam int videoLag = 8;

   ////////////////////
   // Widths and constants
   ////////////////////

   localparam int hcW = 9;
   localparam int vcW = 9;
   localparam int vaW = 14;

   // Red border out of reset
   localparam logic [2:0] resetBorder = 3'd2;

   // Attribute area prefix inside the 16K page
   localparam logic [2:0] attrBase = 3'b110;

   // ULA answers on even port addresses
   localparam logic portSelect = 1'b0;

   // Value on an undriven data bus
   localparam logic [7:0] busIdle = 8'hFF;

   // Per-channel levels of the colour table
   localparam logic [2:0] levelNone = 3'b000;
   localparam logic [2:0] levelHalf = 3'b101;
   localparam logic [2:0] levelFull = 3'b111;

   ////////////////////
   // Bundles
   ////////////////////

   // Z80 I/O request, strobes active low
   typedef struct packed {
      logic [15:0] addr;
      logic        iorqN;
      logic        rdN;
      logic        wrN;
      logic [7:0]  wrData;
   } cpuIoT;

   // GGGRRRBBB colour
   typedef struct packed {
      logic [2:0] g;
      logic [2:0] r;
      logic [2:0] b;
   } rgbT;

   // Beam position
   typedef struct packed {
      logic [hcW-1:0] hc;
      logic [vcW-1:0] vc;
   } rasterT;

   // Strobes from the fetch schedule
   typedef struct packed {
      logic bitmapLoad;
      logic attrLoad;
      logic serializerLoad;
      logic attrOutLoad;
      logic videoEnable;
   } fetchCtlT;

endpackage

/* hw/cpuPorts.sv */
module cpuPorts (
   input  logic          sysclk,
   input  logic          rst_n,
   input  ulaPkg::cpuIoT cpuIo,
   input  logic [4:0]    kbd,
   input  logic          ear,
   input  logic          issue2,
   input  logic          busFetch,
   input  logic [7:0]    vramData,
   output logic [7:0]    cpuData,
   output logic [2:0]    border,
   output logic          mic,
   output logic          spk
);

   logic ulaSel;
   logic portWr;
   logic anyRd;
   logic earFb;

   // Even address with IORQ low selects the ULA port
   assign ulaSel = !cpuIo.iorqN && (cpuIo.addr[0] == ulaPkg::portSelect);
   assign portWr = ulaSel && !cpuIo.wrN;
   assign anyRd  = !cpuIo.iorqN && !cpuIo.rdN;

   ////////////////////
   // Port 0xFE write
   ////////////////////

   // Level sensitive, follows the strobe every clock
   always_ff @(posedge sysclk) begin
      if (!rst_n) begin
         border <= ulaPkg::resetBorder;
         mic    <= 1'b0;
         spk    <= 1'b0;
      end else if (portWr) begin
         border <= cpuIo.wrData[2:0];
         mic    <= cpuIo.wrData[3];
         spk    <= cpuIo.wrData[4];
      end
   end

   // Issue 2 boards also feed MIC back into EAR
   assign earFb = issue2 ? ear ^ (spk | mic) : ear ^ spk;

   ////////////////////
   // Read path
   ////////////////////

   always_comb begin
      cpuData = ulaPkg::busIdle;
      if (anyRd) begin
         if (cpuIo.addr[0] == ulaPkg::portSelect) begin
            cpuData = {1'b1, earFb, 1'b1, kbd};
         end else if (busFetch) begin
            // Floating bus shows the byte the ULA is fetching
            cpuData = vramData;
         end
      end
   end

   // Z80 never drives RD and WR together
   noRdWr: assert property (@(posedge sysclk) disable iff (!rst_n)
      !(!cpuIo.rdN && !cpuIo.wrN));

endmodule

/* hw/rasterCounter.sv */
module rasterCounter (
   input  logic           sysclk,
   input  logic           rst_n,
   output ulaPkg::rasterT raster,
   output logic           hSync,
   output logic           vSync,
   output logic           flashPhase
);

   logic [ulaPkg::hcW-1:0] hc;
   logic [ulaPkg::vcW-1:0] vc;
   logic [4:0]             flashCnt;
   logic                   lineEnd;
   logic                   frameEnd;

   // Last pixel of the line and last line of the frame
   assign lineEnd  = (hc == ulaPkg::hTotal - 1);
   assign frameEnd = (vc == ulaPkg::vTotal - 1);

   ////////////////////
   // Beam counters
   ////////////////////

   always_ff @(posedge sysclk) begin
      if (!rst_n) begin
         hc <= '0;
         vc <= '0;
      end else if (lineEnd) begin
         hc <= '0;
         // Vertical steps only on horizontal wrap
         vc <= frameEnd ? '0 : vc + 1'b1;
      end else begin
         hc <= hc + 1'b1;
      end
   end

   // Frame rate divider, one step per frame
   always_ff @(posedge sysclk) begin
      if (!rst_n) begin
         flashCnt <= '0;
      end else if (hc == '0 && vc == ulaPkg::flashLine) begin
         flashCnt <= flashCnt + 1'b1;
      end
   end

   // Bit 4 toggles every 16 frames
   assign flashPhase = flashCnt[4];

   // Sync decode straight from the counters
   assign hSync = (hc >= ulaPkg::hSyncStart) && (hc <= ulaPkg::hSyncEnd);
   assign vSync = (vc >= ulaPkg::vSyncStart) && (vc <= ulaPkg::vSyncEnd);

   assign raster.hc = hc;
   assign raster.vc = vc;

   // Line counter never leaves the 448 clock line
   hcInRange: assert property (@(posedge sysclk) disable iff (!rst_n)
      hc < ulaPkg::hTotal);

endmodule

/* hw/ulaTop.sv */
module ulaTop (
   input  logic                   sysclk,
   input  logic                   rst_n,
   input  ulaPkg::cpuIoT          cpuIo,
   input  logic [4:0]             kbd,
   input  logic                   ear,
   input  logic                   issue2,
   input  logic [7:0]             vramData,
   output logic [7:0]             cpuData,
   output logic [ulaPkg::vaW-1:0] vramAddr,
   output ulaPkg::rgbT            rgb,
   output ulaPkg::rasterT         raster,
   output logic                   hSync,
   output logic                   vSync,
   output logic                   mic,
   output logic                   spk
);

   ulaPkg::fetchCtlT fetchCtl;
   logic [2:0]       border;
   logic             flashPhase;
   logic             busFetch;

   // Beam position and sync
   rasterCounter u_raster (
      .sysclk     (sysclk),
      .rst_n      (rst_n),
      .raster     (raster),
      .hSync      (hSync),
      .vSync      (vSync),
      .flashPhase (flashPhase)
   );

   // VRAM fetch schedule
   fetchSequencer u_fetch (
      .sysclk   (sysclk),
      .rst_n    (rst_n),
      .raster   (raster),
      .fetchCtl (fetchCtl),
      .vramAddr (vramAddr),
      .busFetch (busFetch)
   );

   // Pixel output path
   pixelPipe u_pixel (
      .sysclk     (sysclk),
      .rst_n      (rst_n),
      .fetchCtl   (fetchCtl),
      .vramData   (vramData),
      .border     (border),
      .flashPhase (flashPhase),
      .rgb        (rgb)
   );

   // Port 0xFE and floating bus
   cpuPorts u_ports (
      .sysclk   (sysclk),
      .rst_n    (rst_n),
      .cpuIo    (cpuIo),
      .kbd      (kbd),
      .ear      (ear),
      .issue2   (issue2),
      .busFetch (busFetch),
      .vramData (vramData),
      .cpuData  (cpuData),
      .border   (border),
      .mic      (mic),
      .spk      (spk)
   );

endmodule

/* test/ulaTests.svh */
`ifndef ULA_TESTS_SVH
`define ULA_TESTS_SVH

////////////////////
// Directed tests
////////////////////

// Border and audio right after reset in frame 0
task automatic verifyResetState();
   ulaPkg::rgbT expColour;
   expColour = refColour({1'b0, expBorder});
   waitBeam(9'd250, 9'd300);
   checkCount++;
   if (rgb !== expColour) begin
      reportMismatch("border colour after reset", rgb, expColour);
   end
   checkCount++;
   if (mic !== 1'b0 || spk !== 1'b0) begin
      reportMismatch("mic/spk after reset", {mic, spk}, 2'b00);
   end
endtask

// Border pixel at hc 300 of the line plus the audio bits
task automatic matchBorderLine(input logic [8:0] line, input string what);
   ulaPkg::rgbT expColour;
   expColour = refColour({1'b0, expBorder});
   waitBeam(line, 9'd300);
   checkCount++;
   if (rgb !== expColour) begin
      reportMismatch({what, " border colour"}, rgb, expColour);
   end
   checkCount++;
   if (mic !== expMic || spk !== expSpk) begin
      reportMismatch({what, " mic/spk"}, {mic, spk}, {expMic, expSpk});
   end
endtask

task automatic exercisePortWrite();
   // Cyan border with speaker on
   ioWrite(16'h00FE, 8'h15);
   matchBorderLine(9'd251, "even write");
   // Magenta border with MIC on
   ioWrite(16'h00FE, 8'h0B);
   matchBorderLine(9'd252, "second even write");
   // Odd port is not the ULA
   ioWrite(16'h00FF, 8'h1C);
   matchBorderLine(9'd253, "odd write");
endtask

task automatic sweepPortRead();
   logic [7:0] data;
   logic [7:0] expData;
   logic       earExp;
   // No fetch in the bottom border so the bus floats high
   waitBeam(9'd250, 9'd20);
   ioRead(16'h00FF, data);
   checkCount++;
   if (data !== 8'hFF) begin
      reportMismatch("odd port read on line 250", data, 8'hFF);
   end
   // Every MIC/speaker pair under both boards and both EAR levels
   for (int audio = 0; audio < 4; audio++) begin
      ioWrite(16'h00FE, {3'b000, audio[1], audio[0], expBorder});
      for (int mode = 0; mode < 4; mode++) begin
         issue2 = mode[1];
         ear    = mode[0];
         kbd    = 5'(randBits(5));
         ioRead(16'h00FE, data);
         earExp  = issue2 ? ear ^ (expSpk | expMic) : ear ^ expSpk;
         expData = {1'b1, earExp, 1'b1, kbd};
         checkCount++;
         if (data !== expData) begin
            reportMismatch($sformatf("port read issue2=%0d ear=%0d", issue2, ear),
                           data, expData);
         end
      end
   end
endtask

task automatic samplePaperPixels();
   logic [7:0]  x;
   logic [7:0]  y;
   logic [8:0]  fetchHc;
   ulaPkg::rgbT expColour;
   for (int k = 0; k < 6; k++) begin
      // One pixel per 32 line band so the walk stays in one frame
      y = 8'(k * 32) + 8'(randBits(5));
      x = 8'(randBits(8));
      // Two cells per 16 clock slot from hc 8, the odd cell four clocks later
      fetchHc = {1'b0, x[7:4], 1'b1, x[3], 2'b00};
      waitBeam({1'b0, y}, fetchHc + 9'd1);
      checkCount++;
      if (vramAddr !== bitmapAddress(x, y)) begin
         reportMismatch($sformatf("bitmap address x=%0d y=%0d", x, y),
                        vramAddr, bitmapAddress(x, y));
      end
      waitBeam({1'b0, y}, fetchHc + 9'd3);
      checkCount++;
      if (vramAddr !== attrAddress(x, y)) begin
         reportMismatch($sformatf("attribute address x=%0d y=%0d", x, y),
                        vramAddr, attrAddress(x, y));
      end
      waitBeam({1'b0, y}, {1'b0, x} + 9'd14);
      expColour = expectedPixel(x, y, frameCnt[4]);
      checkCount++;
      if (rgb !== expColour) begin
         reportMismatch($sformatf("paper pixel x=%0d y=%0d", x, y), rgb, expColour);
      end
   end
endtask

// Sync outputs at one beam position
task automatic expectSyncAt(input logic [8:0] line, input logic [8:0] hcPos,
                            input logic expH, input logic expV);
   waitBeam(line, hcPos);
   checkCount++;
   if (hSync !== expH || vSync !== expV) begin
      reportMismatch($sformatf("sync at line %0d hc %0d", line, hcPos),
                     {hSync, vSync}, {expH, expV});
   end
endtask

// Both edges of each sync pulse
task automatic probeSyncEdges();
   expectSyncAt(9'd247, 9'd0, 1'b0, 1'b0);
   expectSyncAt(9'd248, 9'd343, 1'b0, 1'b1);
   expectSyncAt(9'd248, 9'd344, 1'b1, 1'b1);
   expectSyncAt(9'd248, 9'd375, 1'b1, 1'b1);
   expectSyncAt(9'd248, 9'd376, 1'b0, 1'b1);
   expectSyncAt(9'd251, 9'd0, 1'b0, 1'b1);
   expectSyncAt(9'd252, 9'd0, 1'b0, 1'b0);
endtask

task automatic watchFlashToggle();
   logic [7:0]  x;
   logic [7:0]  y;
   int          startFrame;
   ulaPkg::rgbT firstColour;
   ulaPkg::rgbT expColour;
   x = 8'(randBits(8));
   y = 8'(randBits(7)) + 8'd32;
   // Flash on with yellow paper and blue ink
   vram[attrAddress(x, y)] = 8'b1011_0001;
   waitBeam({1'b0, y}, {1'b0, x} + 9'd14);
   startFrame  = frameCnt;
   firstColour = rgb;
   expColour   = expectedPixel(x, y, frameCnt[4]);
   checkCount++;
   if (rgb !== expColour) begin
      reportMismatch("flash pixel before toggle", rgb, expColour);
   end
   // Same pixel sixteen frames on with the flash phase inverted
   waitBeam({1'b0, y}, {1'b0, x} + 9'd14);
   while (frameCnt != startFrame + 16) begin
      waitBeam({1'b0, y}, {1'b0, x} + 9'd14);
   end
   expColour = expectedPixel(x, y, frameCnt[4]);
   checkCount++;
   if (rgb !== expColour) begin
      reportMismatch("flash pixel after toggle", rgb, expColour);
   end
   checkCount++;
   if (rgb === firstColour) begin
      errorCount++;
      $display("Flash pixel kept colour %0h across 16 frames, ink and paper did not swap",
               rgb);
   end
endtask

`endif

/* test/ulaTb.sv */
module ulaTb;

   // Whole run is 20 frames of tests plus two frames of slack
   localparam longint clkPeriod    = 100;
   localparam longint frameTime    = longint'(ulaPkg::hTotal) * ulaPkg::vTotal * clkPeriod;
   localparam longint watchdogTime = frameTime * 22;

   // Inputs change this long after the rising edge
   localparam int driveSkew = 10;

   localparam logic [31:0] lfsrSeed = 32'h84f759fb;
   localparam logic [31:0] lfsrTaps = 32'h80200003;

   logic                   sysclk;
   logic                   rst_n;
   ulaPkg::cpuIoT          cpuIo;
   logic [4:0]             kbd;
   logic                   ear;
   logic                   issue2;
   logic [7:0]             vramData;
   logic [7:0]             cpuData;
   logic [ulaPkg::vaW-1:0] vramAddr;
   ulaPkg::rgbT            rgb;
   ulaPkg::rasterT         raster;
   logic                   hSync;
   logic                   vSync;
   logic                   mic;
   logic                   spk;

   // 16K video RAM model answering combinationally
   logic [7:0] vram [0:(1 << ulaPkg::vaW) - 1];
   assign vramData = vram[vramAddr];

   logic [31:0] lfsrState;
   int          frameCnt;
   int          errorCount;
   int          checkCount;

   // Port state expected from the writes issued so far
   logic [2:0] expBorder;
   logic       expMic;
   logic       expSpk;

   ulaTop u_ulaTop (
      .sysclk   (sysclk),
      .rst_n    (rst_n),
      .cpuIo    (cpuIo),
      .kbd      (kbd),
      .ear      (ear),
      .issue2   (issue2),
      .vramData (vramData),
      .cpuData  (cpuData),
      .vramAddr (vramAddr),
      .rgb      (rgb),
      .raster   (raster),
      .hSync    (hSync),
      .vSync    (vSync),
      .mic      (mic),
      .spk      (spk)
   );

   initial sysclk = 1'b0;
   always #50 sysclk = ~sysclk;

   // Frame number as seen in the middle of each clock
   always @(negedge sysclk) begin
      if (!rst_n) begin
         frameCnt <= 0;
      end else if (raster.hc == ulaPkg::hTotal - 1 && raster.vc == ulaPkg::vTotal - 1) begin
         frameCnt <= frameCnt + 1;
      end
   end

   ////////////////////
   // Random source
   ////////////////////

   // Right shifting Galois step
   function automatic logic [31:0] lfsrNext(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ lfsrTaps) : (s >> 1);
   endfunction

   // One LFSR step per bit handed out
   function automatic logic [31:0] randBits(input int n);
      logic [31:0] value;
      value = '0;
      for (int i = 0; i < n; i++) begin
         value     = {value[30:0], lfsrState[0]};
         lfsrState = lfsrNext(lfsrState);
      end
      return value;
   endfunction

   ////////////////////
   // Reference model
   ////////////////////

   // IGRB to GGGRRRBBB with black staying black
   function automatic ulaPkg::rgbT refColour(input logic [3:0] idx);
      ulaPkg::rgbT colour;
      logic [2:0]  lit;
      lit      = idx[3] ? ulaPkg::levelFull : ulaPkg::levelHalf;
      colour.g = ulaPkg::levelNone;
      colour.r = ulaPkg::levelNone;
      colour.b = ulaPkg::levelNone;
      if (idx[2]) begin
         colour.g = lit;
      end
      if (idx[1]) begin
         colour.r = lit;
      end
      if (idx[0]) begin
         colour.b = lit;
      end
      return colour;
   endfunction

   // Third, pixel row, char row, then column
   function automatic logic [13:0] bitmapAddress(input logic [7:0] x, input logic [7:0] y);
      return {1'b0, y[7:6], y[2:0], y[5:3], x[7:3]};
   endfunction

   // Attribute map starts at 0x1800
   function automatic logic [13:0] attrAddress(input logic [7:0] x, input logic [7:0] y);
      return {1'b0, 3'b110, y[7:3], x[7:3]};
   endfunction

   function automatic ulaPkg::rgbT expectedPixel(input logic [7:0] x, input logic [7:0] y,
                                                 input logic phase);
      logic [7:0] pattern;
      logic [7:0] attr;
      logic       inkOn;
      pattern = vram[bitmapAddress(x, y)];
      attr    = vram[attrAddress(x, y)];
      // Leftmost pixel is bit 7 and flash inverts on the slow phase
      inkOn = pattern[3'd7 - x[2:0]] ^ (attr[7] & phase);
      if (inkOn) begin
         return refColour({attr[6], attr[2:0]});
      end else begin
         return refColour({attr[6], attr[5:3]});
      end
   endfunction

   ////////////////////
   // Bus helpers
   ////////////////////

   // Returns mid clock with the beam at (line, hcPos)
   task automatic waitBeam(input logic [8:0] line, input logic [8:0] hcPos);
      @(negedge sysclk);
      while (raster.vc != line || raster.hc != hcPos) begin
         @(negedge sysclk);
      end
   endtask

   // One clock of IORQ and WR low
   task automatic ioWrite(input logic [15:0] addr, input logic [7:0] data);
      @(posedge sysclk);
      #driveSkew;
      cpuIo.addr   = addr;
      cpuIo.wrData = data;
      cpuIo.iorqN  = 1'b0;
      cpuIo.wrN    = 1'b0;
      @(posedge sysclk);
      #driveSkew;
      cpuIo.iorqN = 1'b1;
      cpuIo.wrN   = 1'b1;
      // Only the even port keeps border and audio
      if (!addr[0]) begin
         expBorder = data[2:0];
         expMic    = data[3];
         expSpk    = data[4];
      end
   endtask

   // Read data sampled mid clock while the strobes are low
   task automatic ioRead(input logic [15:0] addr, output logic [7:0] data);
      @(posedge sysclk);
      #driveSkew;
      cpuIo.addr  = addr;
      cpuIo.iorqN = 1'b0;
      cpuIo.rdN   = 1'b0;
      @(negedge sysclk);
      data = cpuData;
      @(posedge sysclk);
      #driveSkew;
      cpuIo.iorqN = 1'b1;
      cpuIo.rdN   = 1'b1;
   endtask

   task automatic reportMismatch(input string what, input logic [15:0] got,
                                 input logic [15:0] exp);
      errorCount++;
      $display("CHECK FAILED @%0t: %s, got %0h, expected %0h", $time, what, got, exp);
   endtask

   `include "ulaTests.svh"

   ////////////////////
   // Run
   ////////////////////

   initial begin
      #(watchdogTime);
      $display("Watchdog expired at %0t before the tests completed", $time);
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      lfsrState  = lfsrSeed;
      errorCount = 0;
      checkCount = 0;
      expBorder  = 3'd2;
      expMic     = 1'b0;
      expSpk     = 1'b0;
      // VRAM contents straight off the LFSR
      for (int a = 0; a < (1 << ulaPkg::vaW); a++) begin
         vram[a] = 8'(randBits(8));
      end
      rst_n        = 1'b0;
      cpuIo.addr   = '0;
      cpuIo.iorqN  = 1'b1;
      cpuIo.rdN    = 1'b1;
      cpuIo.wrN    = 1'b1;
      cpuIo.wrData = '0;
      kbd          = 5'h1F;
      ear          = 1'b0;
      issue2       = 1'b0;
      repeat (10) @(posedge sysclk);
      #driveSkew;
      rst_n = 1'b1;

      verifyResetState();
      exercisePortWrite();
      sweepPortRead();
      samplePaperPixels();
      probeSyncEdges();
      watchFlashToggle();

      $display("Checks run %0d, errors %0d", checkCount, errorCount);
      if (errorCount == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* ula.f */
+incdir+test
common/ulaPkg.sv
hw/rasterCounter.sv
video/fetchSequencer.sv
video/pixelPipe.sv
hw/cpuPorts.sv
hw/ulaTop.sv
test/ulaTb.sv

/* video/fetchSequencer.sv */
module fetchSequencer (
   input  logic                   sysclk,
   input  logic                   rst_n,
   input  ulaPkg::rasterT         raster,
   output ulaPkg::fetchCtlT       fetchCtl,
   output logic [ulaPkg::vaW-1:0] vramAddr,
   output logic                   busFetch
);

   logic [4:0] col;
   logic       paperLine;
   logic       fetchWin;
   logic       bitmapAddr;
   logic       attrAddr;

   ////////////////////
   // Column register
   ////////////////////

   // Captured mid cell so it is stable for the next fetch pair
   always_ff @(posedge sysclk) begin
      if (!rst_n) begin
         col <= '0;
      end else if (raster.hc[2:0] == 3'd3) begin
         col <= raster.hc[7:3];
      end
   end

   // Paper lines and the fetch window inside them
   assign paperLine = (raster.vc < ulaPkg::paperHeight);
   assign fetchWin  = paperLine && (raster.hc < ulaPkg::paperWidth);

   ////////////////////
   // Fetch schedule
   ////////////////////

   always_comb begin
      bitmapAddr          = 1'b0;
      attrAddr            = 1'b0;
      fetchCtl.bitmapLoad = 1'b0;
      fetchCtl.attrLoad   = 1'b0;
      if (fetchWin) begin
         // Two bitmap/attribute pairs per 16 clock slot
         case (raster.hc[3:0])
            4'd8, 4'd12: begin
               bitmapAddr = 1'b1;
            end
            4'd9, 4'd13: begin
               bitmapAddr          = 1'b1;
               fetchCtl.bitmapLoad = 1'b1;
            end
            4'd10, 4'd14: begin
               attrAddr = 1'b1;
            end
            4'd11, 4'd15: begin
               attrAddr          = 1'b1;
               fetchCtl.attrLoad = 1'b1;
            end
            default: begin
               // First half of the slot is left to the CPU
               bitmapAddr = 1'b0;
            end
         endcase
      end
   end

   // Paper shows one cell after its fetch
   assign fetchCtl.videoEnable = paperLine
                                 && (raster.hc >= ulaPkg::videoLag)
                                 && (raster.hc < ulaPkg::paperWidth + ulaPkg::videoLag);
   assign fetchCtl.serializerLoad = fetchCtl.videoEnable && (raster.hc[2:0] == 3'd4);

   // Attribute output refreshes every cell, border included
   assign fetchCtl.attrOutLoad = (raster.hc[2:0] == 3'd4);

   ////////////////////
   // VRAM address
   ////////////////////

   always_comb begin
      if (bitmapAddr) begin
         // Interleaved layout: third, pixel row, char row, column
         vramAddr = {1'b0, raster.vc[7:6], raster.vc[2:0], raster.vc[5:3], col};
      end else if (attrAddr) begin
         // Linear attribute map after the bitmap
         vramAddr = {1'b0, ulaPkg::attrBase, raster.vc[7:3], col};
      end else begin
         vramAddr = '0;
      end
   end

   // Floating bus sees VRAM data on these cycles
   assign busFetch = bitmapAddr | attrAddr;

   // Each bitmap load is followed two clocks later by its attribute
   bitmapThenAttr: assert property (@(posedge sysclk) disable iff (!rst_n)
      fetchCtl.bitmapLoad |-> !fetchCtl.attrLoad ##2 fetchCtl.attrLoad);

endmodule

/* video/pixelPipe.sv */
module pixelPipe (
   input  logic             sysclk,
   input  logic             rst_n,
   input  ulaPkg::fetchCtlT fetchCtl,
   input  logic [7:0]       vramData,
   input  logic [2:0]       border,
   input  logic             flashPhase,
   output ulaPkg::rgbT      rgb
);

   logic [7:0] bitmapData;
   logic [7:0] attrData;
   logic [7:0] shiftReg;
   logic [7:0] attrNext;
   logic [7:0] attrOut;
   logic       pixel;
   logic       inkSel;
   logic [3:0] igrb;

   ////////////////////
   // Fetch latches
   ////////////////////

   always_ff @(posedge sysclk) begin
      if (fetchCtl.bitmapLoad) begin
         bitmapData <= vramData;
      end
   end

   always_ff @(posedge sysclk) begin
      if (fetchCtl.attrLoad) begin
         attrData <= vramData;
      end
   end

   // Serializer, MSB is the leftmost pixel
   always_ff @(posedge sysclk) begin
      if (!rst_n) begin
         shiftReg <= '0;
      end else if (fetchCtl.serializerLoad) begin
         shiftReg <= bitmapData;
      end else begin
         // Zeros shift in, so border pixels show paper
         shiftReg <= {shiftReg[6:0], 1'b0};
      end
   end

   // Border goes in as paper, ink 0, no bright, no flash
   assign attrNext = fetchCtl.videoEnable ? attrData : {2'b00, border, 3'b000};

   // Attribute in use for the cell now on the serializer
   always_ff @(posedge sysclk) begin
      if (!rst_n) begin
         attrOut <= {2'b00, ulaPkg::resetBorder, 3'b000};
      end else if (fetchCtl.attrOutLoad) begin
         attrOut <= attrNext;
      end
   end

   ////////////////////
   // Colour mixing
   ////////////////////

   assign pixel = shiftReg[7];

   // Flash swaps ink and paper on the slow phase
   assign inkSel = pixel ^ (attrOut[7] & flashPhase);

   // Bright bit on top of the GRB colour
   assign igrb = inkSel ? {attrOut[6], attrOut[2:0]} : {attrOut[6], attrOut[5:3]};

   // IGRB to GGGRRRBBB
   function automatic ulaPkg::rgbT igrbToRgb(input logic [3:0] idx);
      logic [2:0] level;
      level = idx[3] ? ulaPkg::levelFull : ulaPkg::levelHalf;
      // Black stays black with or without bright
      igrbToRgb.g = idx[2] ? level : ulaPkg::levelNone;
      igrbToRgb.r = idx[1] ? level : ulaPkg::levelNone;
      igrbToRgb.b = idx[0] ? level : ulaPkg::levelNone;
   endfunction

   // Output register, pixel x lands at hc x+14
   always_ff @(posedge sysclk) begin
      rgb <= igrbToRgb(igrb);
   end

   // Serializer is only reloaded inside the paper window
   loadInPaper: assert property (@(posedge sysclk) disable iff (!rst_n)
      fetchCtl.serializerLoad |-> fetchCtl.videoEnable);

endmodule
